/* verilog/pll_pkg.sv */
`default_nettype none

package pll_pkg;

  // word widths
  localparam int CTRL_W = 16;  // control word, stands in for vctrl
  localparam int ERR_W  = 12;  // signed phase error in clk cycles
  localparam int ACC_W  = 24;  // nco phase accumulator

  typedef logic        [CTRL_W-1:0] ctrl_t;  // unsigned control
  typedef logic signed [ERR_W-1:0]  err_t;   // positive when ref leads
  typedef logic        [ACC_W-1:0]  freq_t;  // nco frequency word

  // config bus
  typedef logic [2:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // register map
  localparam cfg_addr_t ADDR_KP    = 3'd0;  // proportional shift, 4 bits
  localparam cfg_addr_t ADDR_KI    = 3'd1;  // integral shift, 4 bits
  localparam cfg_addr_t ADDR_DIV   = 3'd2;  // feedback divide ratio, 8 bits
  localparam cfg_addr_t ADDR_FOFS  = 3'd3;  // freq offset, upper 16 bits of freq_t
  localparam cfg_addr_t ADDR_VINIT = 3'd4;  // control while loop is off
  localparam cfg_addr_t ADDR_VLO   = 3'd5;  // clamp low
  localparam cfg_addr_t ADDR_VHI   = 3'd6;  // clamp high
  localparam cfg_addr_t ADDR_CTRL  = 3'd7;  // bit 0 loop_en

  // pfd states
  // UP: ref seen, waiting for fdbk
  // DN: fdbk seen, waiting for ref
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    UP   = 2'd1,
    DN   = 2'd2
  } pfd_state_t;

endpackage

`default_nettype wire

/* verilog/pll_config_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_config_regs import pll_pkg::*; #(
  parameter ctrl_t      VINIT     = 16'h4000,  // reset of vinit
  parameter ctrl_t      VLO       = 16'h0400,  // reset of vlo
  parameter ctrl_t      VHI       = 16'hf000,  // reset of vhi
  parameter logic [7:0] DIV_RESET = 8'd8       // reset of div_ratio
) (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             cfg_we,
  input  wire cfg_addr_t  cfg_addr,
  input  wire cfg_data_t  cfg_wdata,
  output cfg_data_t       cfg_rdata,
  output logic [3:0]      kp_shift,
  output logic [3:0]      ki_shift,
  output logic [7:0]      div_ratio,
  output freq_t           freq_ofs,
  output ctrl_t           vinit,
  output ctrl_t           vlo,
  output ctrl_t           vhi,
  output logic            loop_en
);

  logic [15:0] fofs_hi;  // only the top 16 bits are programmable

  // fine bits of the offset stay zero
  assign freq_ofs = {fofs_hi, {(ACC_W-16){1'b0}}};

  // write decode, fields narrower than 16 bits drop the upper bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      kp_shift  <= 4'd0;
      ki_shift  <= 4'd0;
      div_ratio <= DIV_RESET;
      fofs_hi   <= 16'h0000;
      vinit     <= VINIT;
      vlo       <= VLO;
      vhi       <= VHI;
      loop_en   <= 1'b0;  // loop starts open
    end else if (cfg_we) begin
      case (cfg_addr)
        ADDR_KP:    kp_shift  <= cfg_wdata[3:0];
        ADDR_KI:    ki_shift  <= cfg_wdata[3:0];
        ADDR_DIV:   div_ratio <= cfg_wdata[7:0];
        ADDR_FOFS:  fofs_hi   <= cfg_wdata;
        ADDR_VINIT: vinit     <= cfg_wdata;
        ADDR_VLO:   vlo       <= cfg_wdata;
        ADDR_VHI:   vhi       <= cfg_wdata;
        ADDR_CTRL:  loop_en   <= cfg_wdata[0];
        default:    ;
      endcase
    end
  end

  // readback, combinational on address
  always_comb begin
    case (cfg_addr)
      ADDR_KP:    cfg_rdata = {12'h000, kp_shift};
      ADDR_KI:    cfg_rdata = {12'h000, ki_shift};
      ADDR_DIV:   cfg_rdata = {8'h00, div_ratio};
      ADDR_FOFS:  cfg_rdata = fofs_hi;
      ADDR_VINIT: cfg_rdata = vinit;
      ADDR_VLO:   cfg_rdata = vlo;
      ADDR_VHI:   cfg_rdata = vhi;
      ADDR_CTRL:  cfg_rdata = {15'h0000, loop_en};
      default:    cfg_rdata = 16'h0000;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/pll_phase_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_phase_detector import pll_pkg::*; (
  input  wire   clk,
  input  wire   arst_n,
  input  wire   ref_in,     // reference strobe, one cycle
  input  wire   fdbk,       // divider strobe, one cycle
  output logic  up,
  output logic  dn,
  output err_t  err,        // signed spacing, + when ref leads
  output logic  err_valid   // one cycle with err
);

  localparam int CNT_W = ERR_W - 1;  // magnitude bits
  localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

  pfd_state_t       state;
  logic [CNT_W-1:0] cnt;      // cycles since the first strobe
  logic             hit_up;   // fdbk closes an UP window
  logic             hit_dn;   // ref closes a DN window
  logic             hit_both; // both strobes in the same idle cycle

  assign hit_up   = (state == UP) && fdbk;
  assign hit_dn   = (state == DN) && ref_in;
  assign hit_both = (state == IDLE) && ref_in && fdbk;

  // level outputs are just state decodes
  assign up = (state == UP);
  assign dn = (state == DN);

  // three-state pfd with measuring counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      cnt       <= '0;
      err_valid <= 1'b0;
    end else begin
      err_valid <= 1'b0;  // default, pulse only
      case (state)
        IDLE: begin
          cnt <= CNT_W'(1);  // first cycle in UP/DN counts as 1
          if (hit_both) begin
            err_valid <= 1'b1;  // aligned, zero error
          end else if (ref_in) begin
            state <= UP;
          end else if (fdbk) begin
            state <= DN;
          end
        end
        UP, DN: begin
          if (hit_up || hit_dn) begin
            state     <= IDLE;
            err_valid <= 1'b1;
          end else if (cnt != CNT_MAX) begin
            cnt <= cnt + 1'b1;  // saturate, stay put
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // error value, symmetric limits +-(2^(ERR_W-1)-1)
  always_ff @(posedge clk) begin
    if (hit_up) begin
      err <= $signed({1'b0, cnt});
    end else if (hit_dn) begin
      err <= -$signed({1'b0, cnt});  // fdbk led, ref late
    end else if (hit_both) begin
      err <= '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/pll_loop_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_loop_filter import pll_pkg::*; (
  input  wire        clk,
  input  wire        arst_n,
  input  wire err_t  err,
  input  wire        err_valid,
  input  wire [3:0]  kp_shift,
  input  wire [3:0]  ki_shift,
  input  wire ctrl_t vinit,
  input  wire ctrl_t vlo,
  input  wire ctrl_t vhi,
  input  wire        loop_en,
  output ctrl_t      vctrl
);

  // room for err shifted by 15 plus a full ctrl word and sign
  localparam int SUM_W = ERR_W + CTRL_W + 2;

  typedef logic signed [SUM_W-1:0] sum_t;

  ctrl_t integ_q;    // integral path, holds the cap voltage
  ctrl_t vctrl_q;    // last filtered control
  sum_t  err_w;      // sign-extended error
  sum_t  integ_sum;  // integrator + ki term, before clamp
  sum_t  prop_sum;   // new integrator + kp term, before clamp
  ctrl_t integ_new;
  ctrl_t vctrl_new;

  // zero-extend unsigned control into the signed sum width
  function automatic sum_t widen(input ctrl_t v);
    return $signed({{(SUM_W-CTRL_W){1'b0}}, v});
  endfunction

  // regulator role, bounds the control word
  function automatic ctrl_t clamp(input sum_t x, input ctrl_t lo, input ctrl_t hi);
    sum_t lo_w;
    sum_t hi_w;
    lo_w = widen(lo);
    hi_w = widen(hi);
    if (x > hi_w) begin
      return hi;
    end else if (x < lo_w) begin
      return lo;
    end
    return x[CTRL_W-1:0];  // in range, fits
  endfunction

  assign err_w = {{(SUM_W-ERR_W){err[ERR_W-1]}}, err};

  // integral path first, proportional rides on the clamped integrator
  assign integ_sum = widen(integ_q) + (err_w <<< ki_shift);
  assign integ_new = clamp(integ_sum, vlo, vhi);
  assign prop_sum  = widen(integ_new) + (err_w <<< kp_shift);
  assign vctrl_new = clamp(prop_sum, vlo, vhi);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      integ_q <= '0;
      vctrl_q <= '0;
    end else if (!loop_en) begin
      integ_q <= vinit;  // open loop, preload
      vctrl_q <= vinit;
    end else if (err_valid) begin
      integ_q <= integ_new;  // one update per pfd event
      vctrl_q <= vctrl_new;
    end
  end

  // open loop shows vinit directly, also true during reset
  assign vctrl = loop_en ? vctrl_q : vinit;

endmodule

`default_nettype wire

/* verilog/pll_nco.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_nco import pll_pkg::*; #(
  parameter int unsigned KVCO_SHIFT = 4  // vco gain as a left shift
) (
  input  wire        clk,
  input  wire        arst_n,
  input  wire ctrl_t vctrl,
  input  wire freq_t freq_ofs,
  output logic       outclk   // toggles on every carry, half rate
);

  freq_t          acc_q;      // phase
  freq_t          incr_q;     // registered increment
  freq_t          gain_term;  // vctrl scaled by kvco
  logic [ACC_W:0] acc_sum;    // extra bit is the carry

  // f = fofs + kvco * vctrl, wraps modulo 2^ACC_W
  assign gain_term = freq_t'(vctrl) << KVCO_SHIFT;
  assign acc_sum   = {1'b0, acc_q} + {1'b0, incr_q};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      incr_q <= '0;
      acc_q  <= '0;
      outclk <= 1'b0;
    end else begin
      incr_q <= freq_ofs + gain_term;  // one cycle from vctrl
      acc_q  <= acc_sum[ACC_W-1:0];
      if (acc_sum[ACC_W]) begin
        outclk <= ~outclk;  // overflow, flip the output
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pll_feedback_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_feedback_divider (
  input  wire        clk,
  input  wire        arst_n,
  input  wire        outclk,
  input  wire  [7:0] div_ratio,
  output logic       fdbk       // one-cycle strobe every N-th rise
);

  logic       outclk_d;  // previous outclk
  logic       rise;      // outclk went 0 -> 1
  logic [7:0] edge_cnt;  // rises since the last strobe
  logic [7:0] ratio;     // effective ratio, never 0

  assign ratio = (div_ratio == 8'd0) ? 8'd1 : div_ratio;
  assign rise  = outclk & ~outclk_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outclk_d <= 1'b0;
      edge_cnt <= 8'd0;
      fdbk     <= 1'b0;
    end else begin
      outclk_d <= outclk;
      fdbk     <= 1'b0;
      if (rise) begin
        // >= so a ratio lowered mid-count wraps at once
        if (edge_cnt >= ratio - 8'd1) begin
          edge_cnt <= 8'd0;
          fdbk     <= 1'b1;
        end else begin
          edge_cnt <= edge_cnt + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pll_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_top import pll_pkg::*; #(
  parameter int unsigned KVCO_SHIFT = 4,
  parameter ctrl_t       VINIT      = 16'h4000,
  parameter ctrl_t       VLO        = 16'h0400,
  parameter ctrl_t       VHI        = 16'hf000,
  parameter logic [7:0]  DIV_RESET  = 8'd8
) (
  input  wire            clk,
  input  wire            arst_n,
  input  wire            ref_in,
  input  wire            cfg_we,
  input  wire cfg_addr_t cfg_addr,
  input  wire cfg_data_t cfg_wdata,
  output cfg_data_t      cfg_rdata,
  output logic           outclk,
  output logic           fdbk,
  output logic           up,
  output logic           dn,
  output ctrl_t          vctrl
);

  // register outputs
  logic [3:0] kp_shift;
  logic [3:0] ki_shift;
  logic [7:0] div_ratio;
  freq_t      freq_ofs;
  ctrl_t      vinit;
  ctrl_t      vlo;
  ctrl_t      vhi;
  logic       loop_en;

  // pfd to filter
  err_t       err;
  logic       err_valid;

  pll_config_regs #(.VINIT(VINIT), .VLO(VLO), .VHI(VHI), .DIV_RESET(DIV_RESET)) u_regs (
    .clk(clk), .arst_n(arst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .kp_shift(kp_shift),
    .ki_shift(ki_shift), .div_ratio(div_ratio), .freq_ofs(freq_ofs),
    .vinit(vinit), .vlo(vlo), .vhi(vhi), .loop_en(loop_en)
  );

  pll_phase_detector u_pfd (
    .clk(clk), .arst_n(arst_n), .ref_in(ref_in), .fdbk(fdbk),
    .up(up), .dn(dn), .err(err), .err_valid(err_valid)
  );

  pll_loop_filter u_lpf (
    .clk(clk), .arst_n(arst_n), .err(err), .err_valid(err_valid),
    .kp_shift(kp_shift), .ki_shift(ki_shift), .vinit(vinit),
    .vlo(vlo), .vhi(vhi), .loop_en(loop_en), .vctrl(vctrl)
  );

  pll_nco #(.KVCO_SHIFT(KVCO_SHIFT)) u_nco (
    .clk(clk), .arst_n(arst_n), .vctrl(vctrl), .freq_ofs(freq_ofs), .outclk(outclk)
  );

  pll_feedback_divider u_div (
    .clk(clk), .arst_n(arst_n), .outclk(outclk), .div_ratio(div_ratio), .fdbk(fdbk)
  );

endmodule

`default_nettype wire

/* verification/pll_sva.sv */
`timescale 1ns/10ps
`default_nettype none

// invariants of the detector and the filter clamp, bound into the top level
// where err_valid and the bounds are visible
module pll_sva import pll_pkg::*; (
  input wire        clk,
  input wire        arst_n,
  input wire        up,
  input wire        dn,
  input wire        err_valid,
  input wire ctrl_t vctrl,
  input wire ctrl_t vlo,
  input wire ctrl_t vhi,
  input wire        loop_en
);

  // pfd decodes are exclusive
  a_up_dn_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(up && dn))
    else $error("up and dn high in the same cycle");

  // error strobe never stretches
  a_err_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    err_valid |=> !err_valid)
    else $error("err_valid held for more than one cycle");

  // fresh filter output lands inside stable, ordered bounds
  a_vctrl_range: assert property (@(posedge clk) disable iff (!arst_n)
    (loop_en && $past(loop_en) && $past(err_valid) && $stable(vlo) && $stable(vhi)
      && (vlo <= vhi)) |-> (vctrl >= vlo && vctrl <= vhi))
    else $error("vctrl outside the clamp bounds");

endmodule

bind pll_top pll_sva u_sva (
  .clk(clk), .arst_n(arst_n), .up(up), .dn(dn), .err_valid(err_valid),
  .vctrl(vctrl), .vlo(vlo), .vhi(vhi), .loop_en(loop_en)
);

`default_nettype wire

/* verification/pll_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pll_tb import pll_pkg::*; ;

  localparam int unsigned KVCO  = 4;
  localparam ctrl_t       VINIT = 16'h4000;
  localparam ctrl_t       VLO   = 16'h0400;
  localparam ctrl_t       VHI   = 16'hf000;
  localparam logic [7:0]  DIVR  = 8'd8;
  localparam int          TMO   = 20000;   // cycles per wait
  localparam int          WIN   = 4000;    // open loop window
  localparam int          REF_P = 240;     // ref period for lock
  localparam int          LOCK_TMO = 400000;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      ref_in;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  cfg_data_t cfg_rdata;
  logic      outclk;
  logic      fdbk;
  logic      up;
  logic      dn;
  ctrl_t     vctrl;

  int          cyc = 0;       // free running cycle count
  int          checks = 0;
  int          errors = 0;
  logic [31:0] lfsr = 32'he37c0994;

  pll_top #(.KVCO_SHIFT(KVCO), .VINIT(VINIT), .VLO(VLO), .VHI(VHI), .DIV_RESET(DIVR)) UUT (
    .clk(clk), .arst_n(arst_n), .ref_in(ref_in), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .outclk(outclk), .fdbk(fdbk),
    .up(up), .dn(dn), .vctrl(vctrl)
  );

  always #50 clk = ~clk;  // 100 ns period
  always @(posedge clk) cyc <= cyc + 1;

  // right-shifting galois lfsr
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // carries of an accumulator starting at a0 after n additions of incr
  function automatic longint ref_nco_edges(input longint a0, input longint incr, input int n);
    return (a0 + incr * n) >> ACC_W;
  endfunction

  function automatic longint clip(input longint x, input longint lo, input longint hi);
    if (x > hi) return hi;
    if (x < lo) return lo;
    return x;
  endfunction

  // pi update from a preloaded integrator
  function automatic longint ref_filter(input longint integ, input longint e, input int kp,
                                        input int ki, input longint lo, input longint hi);
    longint i_new;
    i_new = clip(integ + e * (longint'(1) << ki), lo, hi);
    return clip(i_new + e * (longint'(1) << kp), lo, hi);
  endfunction

  task automatic step();
    @(posedge clk);
    #10;  // drive and sample point
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_range(input string name, input longint got, input longint lo,
                             input longint hi);
    checks++;
    assert (got >= lo && got <= hi) else begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h to 0x%h", name, got, lo, hi);
    end
  endtask

  task automatic write_reg(input cfg_addr_t a, input cfg_data_t d);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    step();
    cfg_we    = 1'b0;
  endtask

  task automatic read_reg(input cfg_addr_t a, output cfg_data_t d);
    cfg_addr = a;
    step();  // readback one cycle later
    d = cfg_rdata;
  endtask

  task automatic wait_fdbk(output int t);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (!fdbk && n < TMO);
    checks++;
    assert (fdbk) else begin
      errors++;
      $display("timed out waiting for a feedback strobe");
    end
    t = cyc;
  endtask

  task automatic loop_cfg(input int kp, input int ki);
    write_reg(ADDR_CTRL, 16'h0000);  // open loop so the integrator preloads
    write_reg(ADDR_KP, cfg_data_t'(kp));
    write_reg(ADDR_KI, cfg_data_t'(ki));
    write_reg(ADDR_DIV, 16'd2);
    write_reg(ADDR_FOFS, 16'h0000);
    write_reg(ADDR_VINIT, VINIT);
    write_reg(ADDR_VLO, VLO);
    write_reg(ADDR_VHI, VHI);
    repeat (3) step();  // increment settles
  endtask

  // ref pulse on a feedback strobe closes any open pfd window
  task automatic resync_and_enable(output int t);
    wait_fdbk(t);
    ref_in = 1'b1;
    step();
    ref_in = 1'b0;
    write_reg(ADDR_CTRL, 16'h0001);
  endtask

  task automatic lead_event(input int lead, input int kp, input int ki, output ctrl_t got);
    int t1;
    int t2;
    int per;
    int m;
    loop_cfg(kp, ki);
    wait_fdbk(t1);
    resync_and_enable(t2);
    per = t2 - t1;  // open loop feedback period
    m = 0;
    while (cyc < t2 + per - lead && m < TMO) begin
      step();
      m++;
    end
    ref_in = 1'b1;
    step();
    ref_in = 1'b0;
    check_val("up", up, 1);
    m = 0;
    while (!fdbk && m < TMO) begin
      step();
      m++;
    end
    checks++;
    assert (fdbk) else begin
      errors++;
      $display("timed out waiting for feedback after a leading ref");
    end
    repeat (2) step();
    got = vctrl;
    check_val("vctrl", vctrl, 32'(ref_filter(VINIT, lead, kp, ki, VLO, VHI)));
  endtask

  task automatic lag_event(input int lag, input int kp, input int ki, output ctrl_t got);
    int t;
    loop_cfg(kp, ki);
    resync_and_enable(t);
    wait_fdbk(t);
    for (int i = 1; i <= lag; i++) begin
      step();
      if (i == 1) check_val("dn", dn, 1);
    end
    ref_in = 1'b1;
    step();
    ref_in = 1'b0;
    step();
    got = vctrl;
    check_val("vctrl", vctrl, 32'(ref_filter(VINIT, -lag, kp, ki, VLO, VHI)));
  endtask

  initial begin
    cfg_data_t   rd;
    cfg_data_t   mask;
    logic [31:0] r;
    ctrl_t       v;
    int          div;
    int          fofs;
    int          tog;
    int          nfb;
    longint      incr;
    longint      tmin;
    longint      tmax;
    int          t0;
    int          n;
    int          q[$];
    logic        prev;
    logic        locked;

    arst_n    = 1'b0;
    ref_in    = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (10) @(posedge clk);
    #10;
    arst_n = 1'b1;
    step();

    // 1 reset state
    check_val("up", up, 0);
    check_val("dn", dn, 0);
    check_val("fdbk", fdbk, 0);
    check_val("outclk", outclk, 0);
    check_val("vctrl", vctrl, VINIT);
    read_reg(ADDR_KP, rd);
    check_val("kp", rd, 0);
    read_reg(ADDR_KI, rd);
    check_val("ki", rd, 0);
    read_reg(ADDR_DIV, rd);
    check_val("div", rd, DIVR);
    read_reg(ADDR_FOFS, rd);
    check_val("fofs", rd, 0);
    read_reg(ADDR_VINIT, rd);
    check_val("vinit", rd, VINIT);
    read_reg(ADDR_VLO, rd);
    check_val("vlo", rd, VLO);
    read_reg(ADDR_VHI, rd);
    check_val("vhi", rd, VHI);
    read_reg(ADDR_CTRL, rd);
    check_val("ctrl", rd, 0);

    // 2 random writes with narrow fields masked
    for (int a = 0; a < 8; a++) begin
      rand_bits(16, r);
      case (cfg_addr_t'(a))
        ADDR_KP, ADDR_KI: mask = 16'h000f;
        ADDR_DIV:         mask = 16'h00ff;
        ADDR_CTRL:        mask = 16'h0001;
        default:          mask = 16'hffff;
      endcase
      write_reg(cfg_addr_t'(a), r[15:0]);
      read_reg(cfg_addr_t'(a), rd);
      check_val("cfg_rdata", rd, r[15:0] & mask);
    end

    // 3 open loop toggle and strobe counts
    loop_cfg(0, 0);
    rand_bits(3, r);
    div = int'(r) + 1;
    rand_bits(12, r);
    fofs = int'(r);
    write_reg(ADDR_DIV, cfg_data_t'(div));
    write_reg(ADDR_FOFS, cfg_data_t'(fofs));
    repeat (4) step();
    incr = (longint'(fofs) << (ACC_W - 16)) + (longint'(VINIT) << KVCO);
    incr = incr % (longint'(1) << ACC_W);
    tmin = ref_nco_edges(0, incr, WIN);  // unknown start phase bounds both ends
    tmax = ref_nco_edges((longint'(1) << ACC_W) - 1, incr, WIN);
    tog  = 0;
    nfb  = 0;
    prev = outclk;
    for (int i = 0; i < WIN; i++) begin
      step();
      if (outclk != prev) tog++;
      if (fdbk) nfb++;
      prev = outclk;
    end
    check_range("outclk toggles", tog, tmin, tmax);
    check_range("fdbk strobes", nfb, (tmin / 2) / div, ((tmax + 1) / 2 + div - 1) / div);

    // 4 single events with small gains
    rand_bits(2, r);
    n = int'(r);
    rand_bits(3, r);
    lead_event(4 + int'(r), n + 2, n, v);
    checks++;
    assert (v > VINIT) else begin
      errors++;
      $display("leading ref did not raise vctrl");
    end
    rand_bits(3, r);
    lag_event(3 + int'(r), n + 2, n, v);
    checks++;
    assert (v < VINIT) else begin
      errors++;
      $display("lagging ref did not lower vctrl");
    end

    // 5 clamp at both bounds
    lead_event(100, 10, 10, v);
    check_val("vctrl", v, VHI);
    lag_event(100, 10, 10, v);
    check_val("vctrl", v, VLO);

    // 6 lock to a periodic ref
    loop_cfg(5, 1);
    resync_and_enable(t0);  // resync pulse opens the ref train
    n = 0;
    locked = 1'b0;
    while (!locked && n < LOCK_TMO) begin
      ref_in = ((cyc - t0) % REF_P == 0);
      step();
      n++;
      if (fdbk) begin
        q.push_back(cyc);
        if (q.size() > 9) void'(q.pop_front());
        if (q.size() == 9) begin
          locked = 1'b1;
          for (int k = 1; k < 9; k++) begin
            if (q[k] - q[k-1] > REF_P + 2 || q[k] - q[k-1] < REF_P - 2) locked = 1'b0;
          end
        end
      end
    end
    ref_in = 1'b0;
    checks++;
    assert (locked) else begin
      errors++;
      $display("loop did not lock to the ref period in time");
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/pll_pkg.sv
verilog/pll_config_regs.sv
verilog/pll_phase_detector.sv
verilog/pll_loop_filter.sv
verilog/pll_nco.sv
verilog/pll_feedback_divider.sv
verilog/pll_top.sv
verification/pll_sva.sv
verification/pll_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := pll_tb
FILELIST  := sources.f
BUILD     := obj_dir
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
